/* hdl/axi_pkg.sv */
`default_nettype none

package axi_pkg;

  // Bus geometry defaults for the top level
  localparam int AXI_ADDR_WIDTH_DEF = 8;
  localparam int AXI_DATA_WIDTH_DEF = 64;

  // Beat index from the burst address generators to the frame buffer
  typedef logic [AXI_ADDR_WIDTH_DEF-1:0] beat_idx_t;

  // Burst encodings as on the AxBURST wires
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  // Response encodings, this slave only answers OKAY
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // Address phase fields, shared by AW and AR
  typedef struct packed {
    logic [AXI_ADDR_WIDTH_DEF-1:0] addr;
    logic [7:0]                    len;
    axi_burst_e                    burst;
  } axi_addr_req_t;

endpackage

`default_nettype wire

/* hdl/benes_pkg.sv */
`default_nettype none

package benes_pkg;

  // Four-lane Benes plane geometry
  localparam int LANE_NUM   = 4;
  localparam int STAGE_NUM  = 3;
  localparam int SWITCH_NUM = 2;

  // Lane slots 0..3 plus the control slot
  localparam int SLOT_NUM  = 5;
  localparam int CTRL_SLOT = 4;

  // One bus beat split into two halves
  localparam int BEAT_WIDTH = 64;
  localparam int HALF_WIDTH = BEAT_WIDTH / 2;
  localparam int CTRL_PAD   = HALF_WIDTH - SWITCH_NUM * STAGE_NUM;

  // One bit per switch, stage 0 in the low bits
  typedef logic [SWITCH_NUM-1:0] stage_sel_t;
  typedef stage_sel_t [STAGE_NUM-1:0] plane_sel_t;

  typedef struct packed {
    logic [HALF_WIDTH-1:0] module_word;
    logic [HALF_WIDTH-1:0] ram_word;
  } lane_view_t;

  // Select words sit at the bottom of each half
  typedef struct packed {
    logic [CTRL_PAD-1:0] pad_hi;
    plane_sel_t          slot_sel;
    logic [CTRL_PAD-1:0] pad_lo;
    plane_sel_t          module_sel;
  } ctrl_view_t;

  typedef union packed {
    lane_view_t lane;
    ctrl_view_t ctrl;
  } beat_u;

endpackage

`default_nettype wire

/* hdl/axi_burst_addr.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_burst_addr #(
  parameter int ADDR_WIDTH = axi_pkg::AXI_ADDR_WIDTH_DEF,
  parameter int DATA_WIDTH = axi_pkg::AXI_DATA_WIDTH_DEF
) (
  input  wire                         S_AXI_ACLK,
  input  wire                         S_AXI_ARESETN,
  input  wire                         i_start,
  input  wire axi_pkg::axi_addr_req_t i_req,
  input  wire                         i_step,
  output axi_pkg::beat_idx_t          o_beat_idx,
  output logic                        o_last
);

  import axi_pkg::*;

  localparam int ADDR_LSB  = $clog2(DATA_WIDTH / 8);
  localparam int BEAT_BITS = ADDR_WIDTH - ADDR_LSB;

  // Address kept in beat units, byte offset is dropped
  logic [BEAT_BITS-1:0] beat_q;
  logic [BEAT_BITS-1:0] beat_inc;
  logic [BEAT_BITS-1:0] wrap_mask;
  logic [7:0]           len_q;
  logic [7:0]           cnt_q;
  axi_burst_e           burst_q;

  // Wrap window of len+1 beats, len is 1, 3, 7 or 15
  assign wrap_mask = BEAT_BITS'(len_q);
  assign beat_inc  = beat_q + 1'b1;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      beat_q  <= '0;
      len_q   <= '0;
      cnt_q   <= '0;
      burst_q <= BURST_FIXED;
    end else if (i_start) begin
      beat_q  <= i_req.addr[ADDR_WIDTH-1:ADDR_LSB];
      len_q   <= i_req.len;
      cnt_q   <= '0;
      burst_q <= i_req.burst;
    end else if (i_step) begin
      cnt_q <= cnt_q + 8'd1;
      case (burst_q)
        BURST_INCR: beat_q <= beat_inc;
        // Upper bits stay, low bits roll inside the window
        BURST_WRAP: beat_q <= (beat_q & ~wrap_mask) | (beat_inc & wrap_mask);
        default:    beat_q <= beat_q;
      endcase
    end
  end

  assign o_last     = (cnt_q == len_q);
  assign o_beat_idx = beat_idx_t'(beat_q);

endmodule

`default_nettype wire

/* hdl/axi_write_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_write_ctrl #(
  parameter int ADDR_WIDTH = axi_pkg::AXI_ADDR_WIDTH_DEF,
  parameter int DATA_WIDTH = axi_pkg::AXI_DATA_WIDTH_DEF
) (
  input  wire                      S_AXI_ACLK,
  input  wire                      S_AXI_ARESETN,
  input  wire [ADDR_WIDTH-1:0]     i_awaddr,
  input  wire [7:0]                i_awlen,
  input  wire axi_pkg::axi_burst_e i_awburst,
  input  wire                      i_awvalid,
  output logic                     o_awready,
  input  wire [DATA_WIDTH-1:0]     i_wdata,
  input  wire                      i_wlast,
  input  wire                      i_wvalid,
  output logic                     o_wready,
  output logic                     o_bvalid,
  output axi_pkg::axi_resp_e       o_bresp,
  input  wire                      i_bready,
  input  wire                      i_other_busy,
  output logic                     o_busy,
  output logic                     o_slot_we,
  output axi_pkg::beat_idx_t       o_slot_idx,
  output logic [DATA_WIDTH-1:0]    o_slot_data
);

  import axi_pkg::*;

  typedef enum logic [1:0] {
    W_IDLE,
    W_ADDR,
    W_DATA,
    W_RESP
  } wr_state_e;

  wr_state_e     state_q;
  axi_addr_req_t aw_req;
  logic          aw_hs;
  logic          w_hs;
  logic          beat_last;

  assign aw_req = '{addr: i_awaddr, len: i_awlen, burst: i_awburst};
  assign aw_hs  = o_awready & i_awvalid;
  assign w_hs   = o_wready & i_wvalid;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      state_q <= W_IDLE;
    end else begin
      case (state_q)
        W_IDLE: if (i_awvalid && !i_other_busy) state_q <= W_ADDR;
        // AWREADY is a single-cycle pulse
        W_ADDR: state_q <= aw_hs ? W_DATA : W_IDLE;
        // Close on WLAST, or on the counted last beat
        W_DATA: if (w_hs && (i_wlast || beat_last)) state_q <= W_RESP;
        W_RESP: if (i_bready) state_q <= W_IDLE;
        default: state_q <= W_IDLE;
      endcase
    end
  end

  assign o_awready = (state_q == W_ADDR);
  assign o_wready  = (state_q == W_DATA);
  assign o_bvalid  = (state_q == W_RESP);
  assign o_bresp   = RESP_OKAY;

  // A pending AWVALID claims the bus so the write wins a tie
  assign o_busy = (state_q != W_IDLE) || i_awvalid;

  assign o_slot_we   = w_hs;
  assign o_slot_data = i_wdata;

  axi_burst_addr #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_aw_addr (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .i_start      (aw_hs),
    .i_req        (aw_req),
    .i_step       (w_hs),
    .o_beat_idx   (o_slot_idx),
    .o_last       (beat_last)
  );

endmodule

`default_nettype wire

/* hdl/axi_read_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_ctrl #(
  parameter int ADDR_WIDTH = axi_pkg::AXI_ADDR_WIDTH_DEF,
  parameter int DATA_WIDTH = axi_pkg::AXI_DATA_WIDTH_DEF
) (
  input  wire                      S_AXI_ACLK,
  input  wire                      S_AXI_ARESETN,
  input  wire [ADDR_WIDTH-1:0]     i_araddr,
  input  wire [7:0]                i_arlen,
  input  wire axi_pkg::axi_burst_e i_arburst,
  input  wire                      i_arvalid,
  output logic                     o_arready,
  output logic                     o_rvalid,
  output logic [DATA_WIDTH-1:0]    o_rdata,
  output axi_pkg::axi_resp_e       o_rresp,
  output logic                     o_rlast,
  input  wire                      i_rready,
  input  wire                      i_other_busy,
  output logic                     o_busy,
  output axi_pkg::beat_idx_t       o_rd_idx,
  input  wire [DATA_WIDTH-1:0]     i_rd_data
);

  import axi_pkg::*;

  typedef enum logic [1:0] {
    R_IDLE,
    R_ADDR,
    R_DATA
  } rd_state_e;

  rd_state_e     state_q;
  axi_addr_req_t ar_req;
  logic          ar_hs;
  logic          r_hs;
  logic          beat_last;

  assign ar_req = '{addr: i_araddr, len: i_arlen, burst: i_arburst};
  assign ar_hs  = o_arready & i_arvalid;
  assign r_hs   = o_rvalid & i_rready;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      state_q <= R_IDLE;
    end else begin
      case (state_q)
        R_IDLE: if (i_arvalid && !i_other_busy) state_q <= R_ADDR;
        R_ADDR: state_q <= ar_hs ? R_DATA : R_IDLE;
        R_DATA: if (r_hs && beat_last) state_q <= R_IDLE;
        default: state_q <= R_IDLE;
      endcase
    end
  end

  assign o_arready = (state_q == R_ADDR);
  assign o_rvalid  = (state_q == R_DATA);
  assign o_rlast   = (state_q == R_DATA) && beat_last;
  assign o_rresp   = RESP_OKAY;
  assign o_busy    = (state_q != R_IDLE);

  // Result word follows the beat index, steady while RREADY is low
  assign o_rdata = i_rd_data;

  axi_burst_addr #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_ar_addr (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .i_start      (ar_hs),
    .i_req        (ar_req),
    .i_step       (r_hs),
    .o_beat_idx   (o_rd_idx),
    .o_last       (beat_last)
  );

endmodule

`default_nettype wire

/* hdl/frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
  parameter  int DATA_WIDTH = axi_pkg::AXI_DATA_WIDTH_DEF,
  localparam int LANE_WIDTH = DATA_WIDTH / 2
) (
  input  wire                                            S_AXI_ACLK,
  input  wire                                            S_AXI_ARESETN,
  input  wire                                            i_slot_we,
  input  wire axi_pkg::beat_idx_t                        i_slot_idx,
  input  wire [DATA_WIDTH-1:0]                           i_slot_data,
  input  wire axi_pkg::beat_idx_t                        i_rd_idx,
  input  wire [benes_pkg::LANE_NUM-1:0][LANE_WIDTH-1:0]  i_mod_plane_out,
  input  wire [benes_pkg::LANE_NUM-1:0][LANE_WIDTH-1:0]  i_slot_plane_out,
  output logic [benes_pkg::LANE_NUM-1:0][LANE_WIDTH-1:0] o_ram_words,
  output logic [benes_pkg::LANE_NUM-1:0][LANE_WIDTH-1:0] o_module_words,
  output benes_pkg::plane_sel_t                          o_module_sel,
  output benes_pkg::plane_sel_t                          o_slot_sel,
  output logic [DATA_WIDTH-1:0]                          o_rd_data
);

  import axi_pkg::*;
  import benes_pkg::*;

  localparam int LANE_IDX_W = $clog2(LANE_NUM);
  localparam int SLOT_IDX_W = $clog2(SLOT_NUM);

  logic [SLOT_NUM-1:0][DATA_WIDTH-1:0] slot_q;
  logic [LANE_NUM-1:0][DATA_WIDTH-1:0] result_q;
  logic                                commit_q;
  logic                                slot_hit;
  beat_u [LANE_NUM-1:0]                lane_beat;
  beat_u                               ctrl_beat;

  // Beats past the control slot are dropped
  assign slot_hit = (i_slot_idx < beat_idx_t'(SLOT_NUM));

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      slot_q   <= '0;
      commit_q <= 1'b0;
    end else begin
      commit_q <= i_slot_we && (i_slot_idx == beat_idx_t'(CTRL_SLOT));
      if (i_slot_we && slot_hit) begin
        slot_q[i_slot_idx[SLOT_IDX_W-1:0]] <= i_slot_data;
      end
    end
  end

  // Planes settle on the new slots, then the frame is latched
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      result_q <= '0;
    end else if (commit_q) begin
      for (int i = 0; i < LANE_NUM; i++) begin
        result_q[i] <= {i_mod_plane_out[i], i_slot_plane_out[i]};
      end
    end
  end

  always_comb begin
    for (int i = 0; i < LANE_NUM; i++) begin
      lane_beat[i]      = beat_u'(slot_q[i]);
      o_ram_words[i]    = lane_beat[i].lane.ram_word;
      o_module_words[i] = lane_beat[i].lane.module_word;
    end
  end

  assign ctrl_beat    = beat_u'(slot_q[CTRL_SLOT]);
  assign o_module_sel = ctrl_beat.ctrl.module_sel;
  assign o_slot_sel   = ctrl_beat.ctrl.slot_sel;

  assign o_rd_data = (i_rd_idx < beat_idx_t'(LANE_NUM)) ?
                     result_q[i_rd_idx[LANE_IDX_W-1:0]] : '0;

endmodule

`default_nettype wire

/* hdl/benes_network.sv */
`timescale 1ns/1ps
`default_nettype none

module benes_network #(
  parameter int LANE_WIDTH = 32
) (
  input  wire [benes_pkg::LANE_NUM-1:0][LANE_WIDTH-1:0]  i_lanes,
  input  wire benes_pkg::plane_sel_t                     i_sel,
  output logic [benes_pkg::LANE_NUM-1:0][LANE_WIDTH-1:0] o_lanes
);

  import benes_pkg::*;

  typedef logic [LANE_NUM-1:0][LANE_WIDTH-1:0] lanes_t;

  lanes_t [STAGE_NUM-1:0] stage_in;
  lanes_t [STAGE_NUM-1:0] stage_out;

  // Inter-stage wiring, lane order 0,2,1,3
  function automatic lanes_t shuffle(input lanes_t x);
    lanes_t y;
    y[0] = x[0];
    y[1] = x[2];
    y[2] = x[1];
    y[3] = x[3];
    return y;
  endfunction

  assign stage_in[0] = i_lanes;

  for (genvar s = 0; s < STAGE_NUM; s++) begin : g_stage
    if (s > 0) begin : g_link
      assign stage_in[s] = shuffle(stage_out[s-1]);
    end
    // Switch k works on lanes 2k and 2k+1
    for (genvar k = 0; k < SWITCH_NUM; k++) begin : g_switch
      assign stage_out[s][2*k]   = i_sel[s][k] ? stage_in[s][2*k+1] : stage_in[s][2*k];
      assign stage_out[s][2*k+1] = i_sel[s][k] ? stage_in[s][2*k]   : stage_in[s][2*k+1];
    end
  end

  assign o_lanes = stage_out[STAGE_NUM-1];

endmodule

`default_nettype wire

/* hdl/benes_axi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module benes_axi_slave #(
  parameter int ADDR_WIDTH = axi_pkg::AXI_ADDR_WIDTH_DEF,
  parameter int DATA_WIDTH = axi_pkg::AXI_DATA_WIDTH_DEF
) (
  input  wire                      S_AXI_ACLK,
  input  wire                      S_AXI_ARESETN,
  input  wire [ADDR_WIDTH-1:0]     i_awaddr,
  input  wire [7:0]                i_awlen,
  input  wire axi_pkg::axi_burst_e i_awburst,
  input  wire                      i_awvalid,
  output logic                     o_awready,
  input  wire [DATA_WIDTH-1:0]     i_wdata,
  input  wire                      i_wlast,
  input  wire                      i_wvalid,
  output logic                     o_wready,
  output logic                     o_bvalid,
  output axi_pkg::axi_resp_e       o_bresp,
  input  wire                      i_bready,
  input  wire [ADDR_WIDTH-1:0]     i_araddr,
  input  wire [7:0]                i_arlen,
  input  wire axi_pkg::axi_burst_e i_arburst,
  input  wire                      i_arvalid,
  output logic                     o_arready,
  output logic                     o_rvalid,
  output logic [DATA_WIDTH-1:0]    o_rdata,
  output axi_pkg::axi_resp_e       o_rresp,
  output logic                     o_rlast,
  input  wire                      i_rready
);

  import axi_pkg::*;
  import benes_pkg::*;

  localparam int LANE_WIDTH = DATA_WIDTH / 2;

  logic                                wr_busy;
  logic                                rd_busy;
  logic                                slot_we;
  beat_idx_t                           slot_idx;
  logic [DATA_WIDTH-1:0]               slot_data;
  beat_idx_t                           rd_idx;
  logic [DATA_WIDTH-1:0]               rd_data;
  logic [LANE_NUM-1:0][LANE_WIDTH-1:0] ram_words;
  logic [LANE_NUM-1:0][LANE_WIDTH-1:0] module_words;
  logic [LANE_NUM-1:0][LANE_WIDTH-1:0] mod_plane_out;
  logic [LANE_NUM-1:0][LANE_WIDTH-1:0] slot_plane_out;
  plane_sel_t                          module_sel;
  plane_sel_t                          slot_sel;

  axi_write_ctrl #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) u_write_ctrl (
    .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
    .i_awaddr(i_awaddr), .i_awlen(i_awlen), .i_awburst(i_awburst),
    .i_awvalid(i_awvalid), .o_awready(o_awready),
    .i_wdata(i_wdata), .i_wlast(i_wlast), .i_wvalid(i_wvalid), .o_wready(o_wready),
    .o_bvalid(o_bvalid), .o_bresp(o_bresp), .i_bready(i_bready),
    .i_other_busy(rd_busy), .o_busy(wr_busy),
    .o_slot_we(slot_we), .o_slot_idx(slot_idx), .o_slot_data(slot_data)
  );

  axi_read_ctrl #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) u_read_ctrl (
    .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
    .i_araddr(i_araddr), .i_arlen(i_arlen), .i_arburst(i_arburst),
    .i_arvalid(i_arvalid), .o_arready(o_arready),
    .o_rvalid(o_rvalid), .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rlast(o_rlast),
    .i_rready(i_rready), .i_other_busy(wr_busy), .o_busy(rd_busy),
    .o_rd_idx(rd_idx), .i_rd_data(rd_data)
  );

  frame_buffer #(.DATA_WIDTH(DATA_WIDTH)) u_frame_buffer (
    .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
    .i_slot_we(slot_we), .i_slot_idx(slot_idx), .i_slot_data(slot_data),
    .i_rd_idx(rd_idx), .i_mod_plane_out(mod_plane_out),
    .i_slot_plane_out(slot_plane_out), .o_ram_words(ram_words),
    .o_module_words(module_words), .o_module_sel(module_sel),
    .o_slot_sel(slot_sel), .o_rd_data(rd_data)
  );

  // RAM-side words through the module-select plane
  benes_network #(.LANE_WIDTH(LANE_WIDTH)) u_module_plane (
    .i_lanes(ram_words), .i_sel(module_sel), .o_lanes(mod_plane_out)
  );

  // Module-side words through the slot-select plane
  benes_network #(.LANE_WIDTH(LANE_WIDTH)) u_slot_plane (
    .i_lanes(module_words), .i_sel(slot_sel), .o_lanes(slot_plane_out)
  );

endmodule

`default_nettype wire

/* verification/benes_axi_slave_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module benes_axi_slave_sva #(
  parameter int DATA_WIDTH = 64
) (
  input wire                  S_AXI_ACLK,
  input wire                  S_AXI_ARESETN,
  input wire                  i_awready,
  input wire                  i_arready,
  input wire                  i_bvalid,
  input wire [1:0]            i_bresp,
  input wire                  i_bready,
  input wire                  i_rvalid,
  input wire [DATA_WIDTH-1:0] i_rdata,
  input wire [1:0]            i_rresp,
  input wire                  i_rlast,
  input wire                  i_rready
);

  // Response must wait for BREADY unchanged
  a_b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
    else $error("BVALID dropped or BRESP changed while BREADY was low");

  a_r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rlast)
      && $stable(i_rresp))
    else $error("RVALID dropped or R payload changed while RREADY was low");

  a_rlast_valid: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    i_rlast |-> i_rvalid)
    else $error("RLAST high without RVALID");

  // One transaction at a time
  a_one_addr: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    !(i_awready && i_arready))
    else $error("AWREADY and ARREADY high in the same cycle");

endmodule

bind benes_axi_slave benes_axi_slave_sva #(.DATA_WIDTH(DATA_WIDTH)) u_sva (
  .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
  .i_awready(o_awready), .i_arready(o_arready),
  .i_bvalid(o_bvalid), .i_bresp(o_bresp), .i_bready(i_bready),
  .i_rvalid(o_rvalid), .i_rdata(o_rdata), .i_rresp(o_rresp),
  .i_rlast(o_rlast), .i_rready(i_rready)
);

`default_nettype wire

/* verification/tb_benes_axi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_benes_axi_slave;

  import axi_pkg::*;

  localparam int          ADDR_WIDTH = 8;
  localparam int          DATA_WIDTH = 64;
  localparam int          NUM_OPS    = 20;
  localparam logic [31:0] SEED       = 32'h05cb_e93b;

  typedef logic [3:0][31:0] lanes_t;

  // One bus transaction of the table, start given in beats
  typedef struct packed {
    logic       is_read;
    logic [4:0] beat;
    logic [7:0] len;
    axi_burst_e burst;
    logic [31:0] seed;
    logic [5:0] module_sel;
    logic [5:0] slot_sel;
  } op_t;

  logic                  S_AXI_ACLK;
  logic                  S_AXI_ARESETN;
  logic [ADDR_WIDTH-1:0] i_awaddr;
  logic [7:0]            i_awlen;
  axi_burst_e            i_awburst;
  logic                  i_awvalid;
  logic                  o_awready;
  logic [DATA_WIDTH-1:0] i_wdata;
  logic                  i_wlast;
  logic                  i_wvalid;
  logic                  o_wready;
  logic                  o_bvalid;
  axi_resp_e             o_bresp;
  logic                  i_bready;
  logic [ADDR_WIDTH-1:0] i_araddr;
  logic [7:0]            i_arlen;
  axi_burst_e            i_arburst;
  logic                  i_arvalid;
  logic                  o_arready;
  logic                  o_rvalid;
  logic [DATA_WIDTH-1:0] o_rdata;
  axi_resp_e             o_rresp;
  logic                  o_rlast;
  logic                  i_rready;

  op_t         ops [NUM_OPS];
  logic [63:0] slot_m [5];
  logic [63:0] result_m [4];
  logic [31:0] stall_rng;
  int          checks;
  int          errors;
  int          cycle_count;
  int          cycle_limit;
  int          cur_op;

  benes_axi_slave #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_benes_axi_slave (
    .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
    .i_awaddr(i_awaddr), .i_awlen(i_awlen), .i_awburst(i_awburst),
    .i_awvalid(i_awvalid), .o_awready(o_awready),
    .i_wdata(i_wdata), .i_wlast(i_wlast), .i_wvalid(i_wvalid), .o_wready(o_wready),
    .o_bvalid(o_bvalid), .o_bresp(o_bresp), .i_bready(i_bready),
    .i_araddr(i_araddr), .i_arlen(i_arlen), .i_arburst(i_arburst),
    .i_arvalid(i_arvalid), .o_arready(o_arready),
    .o_rvalid(o_rvalid), .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rlast(o_rlast),
    .i_rready(i_rready)
  );

  initial begin
    S_AXI_ACLK = 1'b0;
    forever #10 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  always @(posedge S_AXI_ACLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Three stages of swaps, lanes 1 and 2 trade places between stages
  function automatic lanes_t route_plane(input lanes_t lanes, input logic [5:0] sel);
    lanes_t v;
    lanes_t t;
    v = lanes;
    for (int s = 0; s < 3; s++) begin
      if (s > 0) begin
        t = v;
        v[1] = t[2];
        v[2] = t[1];
      end
      for (int k = 0; k < 2; k++) begin
        if (sel[2*s+k]) begin
          t = v;
          v[2*k]   = t[2*k+1];
          v[2*k+1] = t[2*k];
        end
      end
    end
    return v;
  endfunction

  function automatic logic [4:0] next_beat(input logic [4:0] idx, input logic [7:0] len,
                                           input axi_burst_e burst);
    int size;
    int base;
    size = int'(len) + 1;
    base = int'(idx) - (int'(idx) % size);
    case (burst)
      BURST_INCR: return idx + 5'd1;
      BURST_WRAP: return 5'(base + ((int'(idx) + 1) % size));
      default:    return idx;
    endcase
  endfunction

  task automatic commit_frame();
    lanes_t ram_in;
    lanes_t mod_in;
    lanes_t mod_out;
    lanes_t slot_out;
    for (int i = 0; i < 4; i++) begin
      ram_in[i] = slot_m[i][31:0];
      mod_in[i] = slot_m[i][63:32];
    end
    mod_out  = route_plane(ram_in, slot_m[4][5:0]);
    slot_out = route_plane(mod_in, slot_m[4][37:32]);
    for (int i = 0; i < 4; i++) begin
      result_m[i] = {mod_out[i], slot_out[i]};
    end
  endtask

  task automatic compare_word(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch %s: expected %h, got %h", name, exp, got);
    end
  endtask

  function automatic logic stall_draw();
    stall_rng = xorshift32(stall_rng);
    return stall_rng[1:0] != 2'b00;
  endfunction

  task automatic write_burst(input op_t op);
    logic [4:0]  idx;
    logic [63:0] data;
    logic [31:0] rng;
    logic        done;
    rng       = SEED ^ op.seed;
    idx       = op.beat;
    i_awaddr  = {op.beat, 3'b000};
    i_awlen   = op.len;
    i_awburst = op.burst;
    i_awvalid = 1'b1;
    while (!o_awready) @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    i_awvalid = 1'b0;
    for (int b = 0; b <= int'(op.len); b++) begin
      rng = xorshift32(rng);
      data[63:32] = rng;
      rng = xorshift32(rng);
      data[31:0] = rng;
      // Control beat keeps random filler outside the select fields
      if (idx == 5'd4) begin
        data[5:0]   = op.module_sel;
        data[37:32] = op.slot_sel;
      end
      i_wdata  = data;
      i_wlast  = (b == int'(op.len));
      i_wvalid = 1'b1;
      while (!o_wready) @(negedge S_AXI_ACLK);
      @(negedge S_AXI_ACLK);
      if (idx < 5'd5) slot_m[idx] = data;
      if (idx == 5'd4) commit_frame();
      idx = next_beat(idx, op.len, op.burst);
    end
    i_wvalid = 1'b0;
    i_wlast  = 1'b0;
    done     = 1'b0;
    while (!done) begin
      i_bready = stall_draw();
      if (o_bvalid && i_bready) begin
        compare_word($sformatf("o_bresp (op %0d)", cur_op), o_bresp, RESP_OKAY);
        done = 1'b1;
      end
      @(negedge S_AXI_ACLK);
    end
    i_bready = 1'b0;
  endtask

  task automatic read_burst(input op_t op);
    logic [4:0]  idx;
    logic [63:0] exp;
    int          beat;
    idx       = op.beat;
    beat      = 0;
    i_araddr  = {op.beat, 3'b000};
    i_arlen   = op.len;
    i_arburst = op.burst;
    i_arvalid = 1'b1;
    while (!o_arready) @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    i_arvalid = 1'b0;
    while (beat <= int'(op.len)) begin
      i_rready = stall_draw();
      if (o_rvalid && i_rready) begin
        exp = (idx < 5'd4) ? result_m[idx] : 64'h0;
        compare_word($sformatf("o_rdata (op %0d beat %0d)", cur_op, beat), o_rdata, exp);
        compare_word($sformatf("o_rlast (op %0d beat %0d)", cur_op, beat), o_rlast,
                     beat == int'(op.len));
        compare_word($sformatf("o_rresp (op %0d)", cur_op), o_rresp, RESP_OKAY);
        idx  = next_beat(idx, op.len, op.burst);
        beat = beat + 1;
      end
      @(negedge S_AXI_ACLK);
    end
    i_rready = 1'b0;
    compare_word($sformatf("o_rvalid after burst (op %0d)", cur_op), o_rvalid, 1'b0);
  endtask

  initial begin
    int beats;
    S_AXI_ARESETN = 1'b0;
    i_awaddr = '0;
    i_awlen = '0;
    i_awburst = BURST_INCR;
    i_awvalid = 1'b0;
    i_wdata = '0;
    i_wlast = 1'b0;
    i_wvalid = 1'b0;
    i_bready = 1'b0;
    i_araddr = '0;
    i_arlen = '0;
    i_arburst = BURST_INCR;
    i_arvalid = 1'b0;
    i_rready = 1'b0;
    checks = 0;
    errors = 0;
    cycle_count = 0;
    cycle_limit = 0;
    stall_rng = SEED;
    for (int i = 0; i < 5; i++) slot_m[i] = '0;
    for (int i = 0; i < 4; i++) result_m[i] = '0;

    // read flag, start beat, len, burst, payload seed, module_sel, slot_sel
    ops[0]  = '{1'b1, 5'd0, 8'd3,  BURST_INCR,  32'h00, 6'h00, 6'h00};
    ops[1]  = '{1'b0, 5'd0, 8'd3,  BURST_INCR,  32'h11, 6'h00, 6'h00};
    ops[2]  = '{1'b0, 5'd4, 8'd0,  BURST_INCR,  32'h12, 6'h00, 6'h00};
    ops[3]  = '{1'b1, 5'd0, 8'd3,  BURST_INCR,  32'h00, 6'h00, 6'h00};
    ops[4]  = '{1'b0, 5'd0, 8'd4,  BURST_INCR,  32'h13, 6'h1a, 6'h25};
    ops[5]  = '{1'b1, 5'd0, 8'd3,  BURST_INCR,  32'h00, 6'h00, 6'h00};
    ops[6]  = '{1'b0, 5'd4, 8'd0,  BURST_FIXED, 32'h14, 6'h3f, 6'h11};
    ops[7]  = '{1'b1, 5'd2, 8'd3,  BURST_WRAP,  32'h00, 6'h00, 6'h00};
    ops[8]  = '{1'b0, 5'd1, 8'd3,  BURST_FIXED, 32'h15, 6'h00, 6'h00};
    ops[9]  = '{1'b0, 5'd9, 8'd2,  BURST_INCR,  32'h16, 6'h00, 6'h00};
    ops[10] = '{1'b0, 5'd4, 8'd0,  BURST_INCR,  32'h17, 6'h06, 6'h28};
    ops[11] = '{1'b1, 5'd3, 8'd2,  BURST_FIXED, 32'h00, 6'h00, 6'h00};
    ops[12] = '{1'b1, 5'd2, 8'd3,  BURST_INCR,  32'h00, 6'h00, 6'h00};
    ops[13] = '{1'b0, 5'd6, 8'd7,  BURST_WRAP,  32'h18, 6'h2d, 6'h1e};
    ops[14] = '{1'b1, 5'd1, 8'd1,  BURST_WRAP,  32'h00, 6'h00, 6'h00};
    ops[15] = '{1'b1, 5'd5, 8'd15, BURST_WRAP,  32'h00, 6'h00, 6'h00};
    ops[16] = '{1'b0, 5'd3, 8'd3,  BURST_WRAP,  32'h19, 6'h15, 6'h33};
    ops[17] = '{1'b1, 5'd0, 8'd3,  BURST_INCR,  32'h00, 6'h00, 6'h00};
    ops[18] = '{1'b0, 5'd4, 8'd0,  BURST_INCR,  32'h1a, 6'h0b, 6'h38};
    ops[19] = '{1'b1, 5'd0, 8'd4,  BURST_INCR,  32'h00, 6'h00, 6'h00};

    beats = 0;
    for (int i = 0; i < NUM_OPS; i++) beats += int'(ops[i].len) + 1;
    cycle_limit = 4 * beats + 200;

    repeat (8) @(negedge S_AXI_ACLK);
    S_AXI_ARESETN = 1'b1;
    @(negedge S_AXI_ACLK);
    compare_word("o_awready after reset", o_awready, 1'b0);
    compare_word("o_wready after reset", o_wready, 1'b0);
    compare_word("o_bvalid after reset", o_bvalid, 1'b0);
    compare_word("o_arready after reset", o_arready, 1'b0);
    compare_word("o_rvalid after reset", o_rvalid, 1'b0);
    compare_word("o_rlast after reset", o_rlast, 1'b0);

    for (int i = 0; i < NUM_OPS; i++) begin
      cur_op = i;
      if (ops[i].is_read) read_burst(ops[i]);
      else write_burst(ops[i]);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hdl/axi_pkg.sv
hdl/benes_pkg.sv
hdl/axi_burst_addr.sv
hdl/axi_write_ctrl.sv
hdl/axi_read_ctrl.sv
hdl/frame_buffer.sv
hdl/benes_network.sv
hdl/benes_axi_slave.sv
verification/benes_axi_slave_sva.sv
verification/tb_benes_axi_slave.sv

/* Bender.yml */
package:
  name: benes_axi_slave

sources:
  - files:
      - hdl/axi_pkg.sv
      - hdl/benes_pkg.sv
      - hdl/axi_burst_addr.sv
      - hdl/axi_write_ctrl.sv
      - hdl/axi_read_ctrl.sv
      - hdl/frame_buffer.sv
      - hdl/benes_network.sv
      - hdl/benes_axi_slave.sv
  - target: simulation
    files:
      - verification/benes_axi_slave_sva.sv
      - verification/tb_benes_axi_slave.sv
